/* Makefile */
VERILATOR ?= verilator
TOP       ?= regReadTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a listed source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/laneLatch.sv */
module laneLatch
  import regReadPkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic     clk,
  input  logic     rstN_i,

  input  logic     issueValid_i [NUM_LANES],
  input  brMask_t  brMask_i     [NUM_LANES],
  input  payload_t payload_i    [NUM_LANES],
  input  regData_t opAData_i    [NUM_LANES],
  input  regData_t opBData_i    [NUM_LANES],

  // branch resolution from execute
  input  logic     ctrlVerified_i,
  input  logic     ctrlMispredict_i,
  input  ckptId_t  ctrlCkpt_i,

  output logic     issueValid_o [NUM_LANES],
  output regData_t srcAData_o   [NUM_LANES],
  output regData_t srcBData_o   [NUM_LANES],
  output payload_t payload_o    [NUM_LANES]
);

  logic mispredict;
  logic squash [NUM_LANES];

  assign mispredict = ctrlVerified_i && ctrlMispredict_i;

  // kill any lane that sits under the resolved checkpoint
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      squash[l] = mispredict && brMask_i[l][ctrlCkpt_i];
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        issueValid_o[l] <= 1'b0;
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        issueValid_o[l] <= issueValid_i[l] && !squash[l];
      end
    end
  end

  // operands and payload are captured every cycle whatever the valid bit
  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      srcAData_o[l] <= opAData_i[l];
      srcBData_o[l] <= opBData_i[l];
      payload_o[l]  <= payload_i[l];
    end
  end

endmodule

/* design/operandBypass.sv */
module operandBypass
  import regReadPkg::*;
#(
  parameter int NUM_LANES = 2
) (
  // source tags of the instructions being read
  input  physTag_t srcATag_i [NUM_LANES],
  input  physTag_t srcBTag_i [NUM_LANES],

  // register file read data for those tags
  input  regData_t rfAData_i [NUM_LANES],
  input  regData_t rfBData_i [NUM_LANES],

  // results broadcast on the writeback ports this cycle
  input  logic     wbValid_i [NUM_LANES],
  input  physTag_t wbTag_i   [NUM_LANES],
  input  regData_t wbData_i  [NUM_LANES],

  output regData_t opAData_o [NUM_LANES],
  output regData_t opBData_o [NUM_LANES]
);

  logic aHit [NUM_LANES][NUM_LANES];
  logic bHit [NUM_LANES][NUM_LANES];

  // match every source against every writeback port
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int p = 0; p < NUM_LANES; p++) begin
        aHit[l][p] = wbValid_i[p] && (srcATag_i[l] == wbTag_i[p]);
        bHit[l][p] = wbValid_i[p] && (srcBTag_i[l] == wbTag_i[p]);
      end
    end
  end

  // walk the ports from the top down so port 0 has the final say
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      opAData_o[l] = rfAData_i[l];
      opBData_o[l] = rfBData_i[l];
      for (int p = NUM_LANES - 1; p >= 0; p--) begin
        if (aHit[l][p]) begin
          opAData_o[l] = wbData_i[p];
        end
        if (bHit[l][p]) begin
          opBData_o[l] = wbData_i[p];
        end
      end
    end
  end

endmodule

/* design/physRegFile.sv */
module physRegFile
  import regReadPkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic     clk,
  input  logic     rstN_i,

  // two read ports per lane
  input  physTag_t rdATag_i [NUM_LANES],
  input  physTag_t rdBTag_i [NUM_LANES],

  // one write port per lane
  input  logic     wrEn_i   [NUM_LANES],
  input  physTag_t wrTag_i  [NUM_LANES],
  input  regData_t wrData_i [NUM_LANES],

  output regData_t rdAData_o [NUM_LANES],
  output regData_t rdBData_o [NUM_LANES]
);

  regData_t regs [PHYS_REGS];

  // writes land at the edge in lane order
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int r = 0; r < PHYS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wrEn_i[l]) begin
          regs[wrTag_i[l]] <= wrData_i[l];
        end
      end
    end
  end

  // combinational reads see only writes from earlier cycles
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      rdAData_o[l] = regs[rdATag_i[l]];
      rdBData_o[l] = regs[rdBTag_i[l]];
    end
  end

endmodule

/* design/readyScoreboard.sv */
module readyScoreboard
  import regReadPkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                 clk,
  input  logic                 rstN_i,
  input  logic                 exception_i,

  // registers handed back to the free list
  input  logic                 unmapValid_i [NUM_LANES],
  input  physTag_t             unmapTag_i   [NUM_LANES],

  // early wakeup for results still in flight
  input  logic                 wakeValid_i  [NUM_LANES],
  input  physTag_t             wakeTag_i    [NUM_LANES],

  input  logic                 wbValid_i    [NUM_LANES],
  input  physTag_t             wbTag_i      [NUM_LANES],

  output logic [PHYS_REGS-1:0] phyRegRdy_o
);

  // architectural mappings are ready, renamed ones are not
  localparam logic [PHYS_REGS-1:0] RDY_INIT =
    {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};

  logic [PHYS_REGS-1:0] rdyQ;
  logic [PHYS_REGS-1:0] rdyNext;

  // clears first, then sets, so a set on the same tag survives
  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        rdyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeValid_i[l]) begin
        rdyNext[wakeTag_i[l]] = 1'b1;
      end
      if (wbValid_i[l]) begin
        rdyNext[wbTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      rdyQ <= RDY_INIT;
    end else if (exception_i) begin
      rdyQ <= RDY_INIT;
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

/* design/regRead.sv */
module regRead
  import regReadPkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                 clk,
  input  logic                 rstN_i,

  // issue side
  input  logic                 issueValid_i [NUM_LANES],
  input  physTag_t             srcATag_i    [NUM_LANES],
  input  physTag_t             srcBTag_i    [NUM_LANES],
  input  brMask_t              brMask_i     [NUM_LANES],
  input  payload_t             payload_i    [NUM_LANES],

  // writeback ports
  input  logic                 wbValid_i    [NUM_LANES],
  input  physTag_t             wbTag_i      [NUM_LANES],
  input  regData_t             wbData_i     [NUM_LANES],

  // scoreboard updates
  input  logic                 unmapValid_i [NUM_LANES],
  input  physTag_t             unmapTag_i   [NUM_LANES],
  input  logic                 wakeValid_i  [NUM_LANES],
  input  physTag_t             wakeTag_i    [NUM_LANES],

  input  logic                 ctrlVerified_i,
  input  logic                 ctrlMispredict_i,
  input  ckptId_t              ctrlCkpt_i,
  input  logic                 recover_i,
  input  logic                 exception_i,

  // toward execute
  output logic                 issueValid_o [NUM_LANES],
  output regData_t             srcAData_o   [NUM_LANES],
  output regData_t             srcBData_o   [NUM_LANES],
  output payload_t             payload_o    [NUM_LANES],

  output logic [PHYS_REGS-1:0] phyRegRdy_o
);

  logic     rfWrEn  [NUM_LANES];
  regData_t rfAData [NUM_LANES];
  regData_t rfBData [NUM_LANES];
  regData_t opAData [NUM_LANES];
  regData_t opBData [NUM_LANES];

  // results from squashed paths must not reach the register file
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      rfWrEn[l] = wbValid_i[l] && !recover_i;
    end
  end

  physRegFile #(.NUM_LANES(NUM_LANES)) physRegFileInst (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .rdATag_i  (srcATag_i),
    .rdBTag_i  (srcBTag_i),
    .wrEn_i    (rfWrEn),
    .wrTag_i   (wbTag_i),
    .wrData_i  (wbData_i),
    .rdAData_o (rfAData),
    .rdBData_o (rfBData)
  );

  operandBypass #(.NUM_LANES(NUM_LANES)) operandBypassInst (
    .srcATag_i (srcATag_i),
    .srcBTag_i (srcBTag_i),
    .rfAData_i (rfAData),
    .rfBData_i (rfBData),
    .wbValid_i (wbValid_i),
    .wbTag_i   (wbTag_i),
    .wbData_i  (wbData_i),
    .opAData_o (opAData),
    .opBData_o (opBData)
  );

  laneLatch #(.NUM_LANES(NUM_LANES)) laneLatchInst (
    .clk              (clk),
    .rstN_i           (rstN_i),
    .issueValid_i     (issueValid_i),
    .brMask_i         (brMask_i),
    .payload_i        (payload_i),
    .opAData_i        (opAData),
    .opBData_i        (opBData),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlMispredict_i (ctrlMispredict_i),
    .ctrlCkpt_i       (ctrlCkpt_i),
    .issueValid_o     (issueValid_o),
    .srcAData_o       (srcAData_o),
    .srcBData_o       (srcBData_o),
    .payload_o        (payload_o)
  );

  readyScoreboard #(.NUM_LANES(NUM_LANES)) readyScoreboardInst (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .wbValid_i    (wbValid_i),
    .wbTag_i      (wbTag_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

/* design/regReadPkg.sv */
package regReadPkg;

  // operand and register file sizing
  localparam int unsigned DATA_W = 32;
  localparam int unsigned PHYS_REGS = 64;
  localparam int unsigned PHYS_LOG = 6;

  // physical 0 to ARCH_REGS-1 hold committed state after reset or exception
  localparam int unsigned ARCH_REGS = 32;

  // branch checkpoints tracked by the issue mask
  localparam int unsigned CHECKPOINTS = 4;
  localparam int unsigned CKPT_LOG = 2;

  // opaque issue fields carried alongside the operands
  localparam int unsigned PAYLOAD_W = 16;

  typedef logic [PHYS_LOG-1:0] physTag_t;

  typedef logic [DATA_W-1:0] regData_t;

  // one bit per checkpoint the instruction depends on
  typedef logic [CHECKPOINTS-1:0] brMask_t;

  typedef logic [CKPT_LOG-1:0] ckptId_t;

  typedef logic [PAYLOAD_W-1:0] payload_t;

endpackage

/* verif/regReadTb.sv */
module regReadTb
  import regReadPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANES = 2;
  localparam int unsigned SEED = 11917;
  localparam int RANDOM_ROWS = 24;

  // inputs for one cycle and the outputs expected one cycle later
  typedef struct packed {
    logic [LANES-1:0]     issueValid;
    physTag_t [LANES-1:0] srcATag;
    physTag_t [LANES-1:0] srcBTag;
    brMask_t [LANES-1:0]  brMask;
    payload_t [LANES-1:0] payload;
    logic [LANES-1:0]     wbValid;
    physTag_t [LANES-1:0] wbTag;
    regData_t [LANES-1:0] wbData;
    logic [LANES-1:0]     unmapValid;
    physTag_t [LANES-1:0] unmapTag;
    logic [LANES-1:0]     wakeValid;
    physTag_t [LANES-1:0] wakeTag;
    logic                 ctrlVerified;
    logic                 ctrlMispredict;
    ckptId_t              ctrlCkpt;
    logic                 recover;
    logic                 exception;
    logic [LANES-1:0]     expValid;
    regData_t [LANES-1:0] expA;
    regData_t [LANES-1:0] expB;
    payload_t [LANES-1:0] expPayload;
    logic [PHYS_REGS-1:0] expRdy;
  } stimRow_t;

  logic clk;
  logic rstN;

  logic     issueValid [LANES];
  physTag_t srcATag    [LANES];
  physTag_t srcBTag    [LANES];
  brMask_t  brMask     [LANES];
  payload_t payload    [LANES];
  logic     wbValid    [LANES];
  physTag_t wbTag      [LANES];
  regData_t wbData     [LANES];
  logic     unmapValid [LANES];
  physTag_t unmapTag   [LANES];
  logic     wakeValid  [LANES];
  physTag_t wakeTag    [LANES];
  logic     ctrlVerified;
  logic     ctrlMispredict;
  ckptId_t  ctrlCkpt;
  logic     recover;
  logic     exception;

  logic     validOut   [LANES];
  regData_t srcAOut    [LANES];
  regData_t srcBOut    [LANES];
  payload_t payloadOut [LANES];
  logic [PHYS_REGS-1:0] rdyOut;

  // reference state of register file and scoreboard
  regData_t shadowRf [PHYS_REGS];
  logic [PHYS_REGS-1:0] shadowRdy;

  stimRow_t rows [$];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycleLimit = 0;

  tbClock clockGen (
    .clk    (clk),
    .rstN_o (rstN)
  );

  regRead #(.NUM_LANES(LANES)) uut (
    .clk              (clk),
    .rstN_i           (rstN),
    .issueValid_i     (issueValid),
    .srcATag_i        (srcATag),
    .srcBTag_i        (srcBTag),
    .brMask_i         (brMask),
    .payload_i        (payload),
    .wbValid_i        (wbValid),
    .wbTag_i          (wbTag),
    .wbData_i         (wbData),
    .unmapValid_i     (unmapValid),
    .unmapTag_i       (unmapTag),
    .wakeValid_i      (wakeValid),
    .wakeTag_i        (wakeTag),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCkpt_i       (ctrlCkpt),
    .recover_i        (recover),
    .exception_i      (exception),
    .issueValid_o     (validOut),
    .srcAData_o       (srcAOut),
    .srcBData_o       (srcBOut),
    .payload_o        (payloadOut),
    .phyRegRdy_o      (rdyOut)
  );

  function automatic logic [PHYS_REGS-1:0] rdyResetPattern();
    logic [PHYS_REGS-1:0] v;
    for (int i = 0; i < PHYS_REGS; i++) begin
      v[i] = (i < ARCH_REGS);
    end
    return v;
  endfunction

  // first writeback port carrying the tag wins, else the stored value
  function automatic regData_t expectedOperand(input stimRow_t r, input physTag_t tag);
    for (int p = 0; p < LANES; p++) begin
      if (r.wbValid[p] && r.wbTag[p] == tag) begin
        return r.wbData[p];
      end
    end
    return shadowRf[tag];
  endfunction

  task automatic commitRow(input stimRow_t r);
    stimRow_t e;
    e = r;
    for (int l = 0; l < LANES; l++) begin
      e.expValid[l] = r.issueValid[l] &&
        !(r.ctrlVerified && r.ctrlMispredict && r.brMask[l][r.ctrlCkpt]);
      e.expA[l] = expectedOperand(r, r.srcATag[l]);
      e.expB[l] = expectedOperand(r, r.srcBTag[l]);
      e.expPayload[l] = r.payload[l];
    end
    if (!r.recover) begin
      for (int p = 0; p < LANES; p++) begin
        if (r.wbValid[p]) begin
          shadowRf[r.wbTag[p]] = r.wbData[p];
        end
      end
    end
    if (r.exception) begin
      shadowRdy = rdyResetPattern();
    end else begin
      for (int l = 0; l < LANES; l++) begin
        if (r.unmapValid[l]) shadowRdy[r.unmapTag[l]] = 1'b0;
      end
      for (int l = 0; l < LANES; l++) begin
        if (r.wakeValid[l]) shadowRdy[r.wakeTag[l]] = 1'b1;
        if (r.wbValid[l]) shadowRdy[r.wbTag[l]] = 1'b1;
      end
    end
    e.expRdy = shadowRdy;
    rows.push_back(e);
  endtask

  task automatic buildTable();
    stimRow_t r;
    for (int i = 0; i < PHYS_REGS; i++) begin
      shadowRf[i] = '0;
    end
    shadowRdy = rdyResetPattern();
    r = '0;
    commitRow(r);
    // fill tags 32 to 39, then read them back with lanes swapped
    for (int i = 0; i < 4; i++) begin
      r = '0;
      r.wbValid = 2'b11;
      r.wbTag[0] = physTag_t'(32 + 2 * i);
      r.wbTag[1] = physTag_t'(33 + 2 * i);
      r.wbData[0] = $urandom();
      r.wbData[1] = $urandom();
      commitRow(r);
    end
    for (int i = 0; i < 4; i++) begin
      r = '0;
      r.issueValid = 2'b11;
      r.srcATag[0] = physTag_t'(32 + 2 * i);
      r.srcBTag[0] = physTag_t'(33 + 2 * i);
      r.srcATag[1] = r.srcBTag[0];
      r.srcBTag[1] = r.srcATag[0];
      r.payload[0] = payload_t'($urandom());
      r.payload[1] = payload_t'($urandom());
      commitRow(r);
    end
    // same-cycle forwarding from both ports
    r = '0;
    r.issueValid = 2'b11;
    r.wbValid = 2'b11;
    r.wbTag[0] = 6'd50;
    r.wbTag[1] = 6'd51;
    r.wbData[0] = $urandom();
    r.wbData[1] = $urandom();
    r.srcATag[0] = 6'd50;
    r.srcBTag[0] = 6'd51;
    r.srcATag[1] = 6'd51;
    r.srcBTag[1] = 6'd50;
    commitRow(r);
    // write under recovery forwards but leaves 34 unchanged
    r = '0;
    r.issueValid = 2'b11;
    r.recover = 1'b1;
    r.wbValid[0] = 1'b1;
    r.wbTag[0] = 6'd34;
    r.wbData[0] = $urandom();
    r.srcATag[0] = 6'd34;
    r.srcBTag[0] = 6'd34;
    r.srcATag[1] = 6'd35;
    r.srcBTag[1] = 6'd34;
    commitRow(r);
    r.recover = 1'b0;
    r.wbValid = 2'b00;
    commitRow(r);
    // mispredict on checkpoint 2, then partial conditions, then a hit on both
    r = '0;
    r.issueValid = 2'b11;
    r.srcATag[0] = 6'd32;
    r.srcBTag[1] = 6'd33;
    r.payload[0] = 16'h1234;
    r.payload[1] = 16'hbeef;
    r.ctrlVerified = 1'b1;
    r.ctrlMispredict = 1'b1;
    r.ctrlCkpt = 2'd2;
    r.brMask[0] = 4'b0100;
    r.brMask[1] = 4'b1011;
    commitRow(r);
    r.ctrlMispredict = 1'b0;
    r.brMask[1] = 4'b1111;
    commitRow(r);
    r.ctrlVerified = 1'b0;
    r.ctrlMispredict = 1'b1;
    commitRow(r);
    r.ctrlVerified = 1'b1;
    r.ctrlCkpt = 2'd3;
    r.brMask[0] = 4'b1000;
    r.brMask[1] = 4'b1000;
    commitRow(r);
    // scoreboard clears, sets, set beating clear, exception restore
    r = '0;
    r.unmapValid = 2'b11;
    r.unmapTag[0] = 6'd5;
    r.unmapTag[1] = 6'd6;
    commitRow(r);
    r = '0;
    r.wakeValid = 2'b11;
    r.wakeTag[0] = 6'd40;
    r.wakeTag[1] = 6'd45;
    r.wbValid[0] = 1'b1;
    r.wbTag[0] = 6'd46;
    r.wbData[0] = $urandom();
    commitRow(r);
    r = '0;
    r.unmapValid = 2'b11;
    r.unmapTag[0] = 6'd7;
    r.unmapTag[1] = 6'd8;
    r.wakeValid[1] = 1'b1;
    r.wakeTag[1] = 6'd7;
    r.wbValid[0] = 1'b1;
    r.wbTag[0] = 6'd8;
    r.wbData[0] = $urandom();
    commitRow(r);
    r = '0;
    r.exception = 1'b1;
    commitRow(r);
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      r = '0;
      for (int l = 0; l < LANES; l++) begin
        r.issueValid[l] = 1'($urandom());
        r.brMask[l] = brMask_t'($urandom());
        r.payload[l] = payload_t'($urandom());
        r.wbValid[l] = 1'($urandom());
        r.wbTag[l] = physTag_t'($urandom());
        r.wbData[l] = $urandom();
        r.unmapValid[l] = 1'($urandom());
        r.unmapTag[l] = physTag_t'($urandom());
        r.wakeValid[l] = 1'($urandom());
        r.wakeTag[l] = physTag_t'($urandom());
      end
      if (r.wbTag[1] == r.wbTag[0]) r.wbTag[1] = r.wbTag[0] ^ 6'd1;
      // lean the sources toward the writeback tags to exercise forwarding
      for (int l = 0; l < LANES; l++) begin
        r.srcATag[l] = ($urandom_range(2) == 0) ? r.wbTag[l] : physTag_t'($urandom());
        r.srcBTag[l] = ($urandom_range(2) == 0) ? r.wbTag[1 - l] : physTag_t'($urandom());
      end
      r.ctrlVerified = 1'($urandom());
      r.ctrlMispredict = 1'($urandom());
      r.ctrlCkpt = ckptId_t'($urandom());
      r.recover = ($urandom_range(7) == 0);
      r.exception = ($urandom_range(15) == 0);
      commitRow(r);
    end
  endtask

  task automatic initInputs();
    for (int l = 0; l < LANES; l++) begin
      issueValid[l] = 1'b0;
      srcATag[l] = '0;
      srcBTag[l] = '0;
      brMask[l] = '0;
      payload[l] = '0;
      wbValid[l] = 1'b0;
      wbTag[l] = '0;
      wbData[l] = '0;
      unmapValid[l] = 1'b0;
      unmapTag[l] = '0;
      wakeValid[l] = 1'b0;
      wakeTag[l] = '0;
    end
    ctrlVerified = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCkpt = '0;
    recover = 1'b0;
    exception = 1'b0;
  endtask

  task automatic driveRow(input stimRow_t r);
    for (int l = 0; l < LANES; l++) begin
      issueValid[l] = r.issueValid[l];
      srcATag[l] = r.srcATag[l];
      srcBTag[l] = r.srcBTag[l];
      brMask[l] = r.brMask[l];
      payload[l] = r.payload[l];
      wbValid[l] = r.wbValid[l];
      wbTag[l] = r.wbTag[l];
      wbData[l] = r.wbData[l];
      unmapValid[l] = r.unmapValid[l];
      unmapTag[l] = r.unmapTag[l];
      wakeValid[l] = r.wakeValid[l];
      wakeTag[l] = r.wakeTag[l];
    end
    ctrlVerified = r.ctrlVerified;
    ctrlMispredict = r.ctrlMispredict;
    ctrlCkpt = r.ctrlCkpt;
    recover = r.recover;
    exception = r.exception;
  endtask

  task automatic checkRow(input stimRow_t r, input int idx);
    for (int l = 0; l < LANES; l++) begin
      checks += 4;
      assert (validOut[l] === r.expValid[l]) else begin
        $display("ERROR row %0d issueValid_o[%0d] expected %h got %h",
                 idx, l, r.expValid[l], validOut[l]);
        errors++;
      end
      assert (srcAOut[l] === r.expA[l]) else begin
        $display("ERROR row %0d srcAData_o[%0d] expected %h got %h",
                 idx, l, r.expA[l], srcAOut[l]);
        errors++;
      end
      assert (srcBOut[l] === r.expB[l]) else begin
        $display("ERROR row %0d srcBData_o[%0d] expected %h got %h",
                 idx, l, r.expB[l], srcBOut[l]);
        errors++;
      end
      assert (payloadOut[l] === r.expPayload[l]) else begin
        $display("ERROR row %0d payload_o[%0d] expected %h got %h",
                 idx, l, r.expPayload[l], payloadOut[l]);
        errors++;
      end
    end
    checks++;
    assert (rdyOut === r.expRdy) else begin
      $display("ERROR row %0d phyRegRdy_o expected %h got %h", idx, r.expRdy, rdyOut);
      errors++;
    end
  endtask

  task automatic checkReset();
    for (int l = 0; l < LANES; l++) begin
      checks++;
      assert (validOut[l] === 1'b0) else begin
        $display("ERROR reset issueValid_o[%0d] expected %h got %h", l, 1'b0, validOut[l]);
        errors++;
      end
    end
    checks++;
    assert (rdyOut === rdyResetPattern()) else begin
      $display("ERROR reset phyRegRdy_o expected %h got %h", rdyResetPattern(), rdyOut);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    initInputs();
    buildTable();
    cycleLimit = rows.size() + 20;
    @(posedge rstN);
    #1;
    checkReset();
    // outputs of a row are checked just after the edge that follows it
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #1;
      if (i > 0) checkRow(rows[i - 1], i - 1);
      #1;
      driveRow(rows[i]);
    end
    @(posedge clk);
    #1;
    checkRow(rows[rows.size() - 1], rows.size() - 1);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verif/tbClock.sv */
module tbClock #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rstN_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release lines up with the stimulus offset after an edge
  initial begin
    rstN_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rstN_o = 1'b1;
  end

endmodule

/* verilog.f */
design/regReadPkg.sv
design/physRegFile.sv
design/operandBypass.sv
design/laneLatch.sv
design/readyScoreboard.sv
design/regRead.sv
verif/tbClock.sv
verif/regReadTb.sv
